// File: design/mssdPkg.sv
`default_nettype none

package mssdPkg;

  // ********************
  // Sizes
  // ********************
  localparam int dataWidth        = 32;
  localparam int regCount         = 8;
  localparam int regIdxWidth      = 3;
  localparam int ipWidth          = 16;  // Counts in instructions
  localparam int immWidth         = 16;
  localparam int shiftWidth       = $clog2(dataWidth);
  localparam int insnBufDepth     = 4;   // Also the sender's initial credits
  localparam int insnPtrWidth     = $clog2(insnBufDepth);
  localparam int resultCredits    = 4;
  localparam int creditWidth      = $clog2(resultCredits + 1);
  localparam int resultQueueDepth = 2;
  localparam int queuePtrWidth    = $clog2(resultQueueDepth);

  typedef enum logic [3:0] {
    opAdd = 4'h0,
    opSub = 4'h1,
    opAnd = 4'h2,
    opXor = 4'h3,
    opShl = 4'h4,
    opShr = 4'h5,
    opAsr = 4'h6,
    opRol = 4'h7,
    opBts = 4'h8,
    opBtr = 4'h9,
    opBt  = 4'hA,
    opLdi = 4'hB,
    opJmp = 4'hC
  } mssdOpcode;

  // Same order as the jump condition table
  typedef enum logic [3:0] {
    condAlways = 4'h0,
    condBe     = 4'h1,
    condC      = 4'h2,
    condNc     = 4'h3,
    condZ      = 4'h4,
    condNz     = 4'h5,
    condA      = 4'h6,
    condNone7  = 4'h7,  // Never taken
    condG      = 4'h8,
    condGe     = 4'h9,
    condS      = 4'hA,
    condSe     = 4'hB,
    condN      = 4'hC,
    condV      = 4'hD,
    condNn     = 4'hE,
    condNv     = 4'hF
  } mssdCond;

  typedef struct packed {
    mssdOpcode              opcode;
    mssdCond                cond;
    logic [regIdxWidth-1:0] rd;
    logic [regIdxWidth-1:0] rs;
    logic                   useImm;
    logic                   flagWr;
    logic [immWidth-1:0]    imm;
  } mssdInsn;

  typedef struct packed {
    logic v;
    logic n;
    logic z;
    logic c;
  } mssdFlags;

  typedef struct packed {
    mssdOpcode              opcode;
    mssdCond                cond;
    logic [regIdxWidth-1:0] rd;
    logic [regIdxWidth-1:0] rs;
    logic                   useImm;
    logic                   flagWr;
    logic [dataWidth-1:0]   immExt;
    logic                   regWr;
  } mssdDecoded;

  typedef struct packed {
    logic [ipWidth-1:0]     ip;
    mssdOpcode              opcode;
    logic [regIdxWidth-1:0] rd;
    logic                   regWr;
    logic [dataWidth-1:0]   value;
    mssdFlags               flags;
    logic                   jumpTaken;
  } mssdResult;

endpackage

`default_nettype wire

// File: design/mssdRegFile.sv
`timescale 1ns/100ps
`default_nettype none

module mssdRegFile (
  input  logic                            clkH,
  input  logic                            reset,
  input  logic [mssdPkg::regIdxWidth-1:0] rdIdx,
  input  logic [mssdPkg::regIdxWidth-1:0] rsIdx,
  input  logic [mssdPkg::regIdxWidth-1:0] wrIdx,
  input  logic                            wrEn,
  input  logic [mssdPkg::dataWidth-1:0]   wrData,
  output logic [mssdPkg::dataWidth-1:0]   rdData,
  output logic [mssdPkg::dataWidth-1:0]   rsData
);
  import mssdPkg::*;

  logic [dataWidth-1:0] regs [regCount];

  // Registers start at zero
  always_ff @(posedge clkH) begin
    if (reset) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrIdx] <= wrData;
    end
  end

  // Combinational reads
  assign rdData = regs[rdIdx];
  assign rsData = regs[rsIdx];

endmodule

`default_nettype wire

// File: design/mssdDecode.sv
`timescale 1ns/100ps
`default_nettype none

module mssdDecode (
  input  logic                clkH,
  input  logic                reset,
  input  mssdPkg::mssdInsn    insn,
  input  logic                insnValid,
  input  logic                execHold,
  output logic                insnCredit,
  output mssdPkg::mssdDecoded decodedOp,
  output logic                decValid
);
  import mssdPkg::*;

  mssdInsn                 bufMem [insnBufDepth];
  logic [insnPtrWidth-1:0] wrPtr;
  logic [insnPtrWidth-1:0] rdPtr;
  logic [insnPtrWidth:0]   bufCount;
  logic                    bufEmpty;
  logic                    drain;
  mssdInsn                 headInsn;
  mssdDecoded              decNext;

  // ********************
  // Instruction buffer
  // ********************

  // Sender never exceeds its credits, so no full check here
  always_ff @(posedge clkH) begin
    if (insnValid) begin
      bufMem[wrPtr] <= insn;
    end
  end

  assign bufEmpty = (bufCount == '0);
  assign drain    = ~bufEmpty & ~execHold;
  assign headInsn = bufMem[rdPtr];

  always_ff @(posedge clkH) begin
    if (reset) begin
      wrPtr      <= '0;
      rdPtr      <= '0;
      bufCount   <= '0;
      insnCredit <= 1'b0;
    end else begin
      if (insnValid) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (drain) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({insnValid, drain})
        2'b10:   bufCount <= bufCount + 1'b1;
        2'b01:   bufCount <= bufCount - 1'b1;
        default: bufCount <= bufCount;
      endcase
      insnCredit <= drain;  // One credit per word leaving the buffer
    end
  end

  // ********************
  // Decode register
  // ********************

  always_comb begin
    decNext.opcode = headInsn.opcode;
    decNext.cond   = headInsn.cond;
    decNext.rd     = headInsn.rd;
    decNext.rs     = headInsn.rs;
    decNext.useImm = headInsn.useImm;
    decNext.flagWr = headInsn.flagWr;
    decNext.immExt = {{(dataWidth - immWidth){headInsn.imm[immWidth-1]}}, headInsn.imm};
    // bt only tests, jmp only moves ip
    decNext.regWr  = !(headInsn.opcode inside {opBt, opJmp});
  end

  always_ff @(posedge clkH) begin
    if (reset) begin
      decValid <= 1'b0;
    end else if (!execHold) begin
      decValid <= ~bufEmpty;
    end
  end

  always_ff @(posedge clkH) begin
    if (drain) begin
      decodedOp <= decNext;
    end
  end

endmodule

`default_nettype wire

// File: design/mssdExecute.sv
`timescale 1ns/100ps
`default_nettype none

module mssdExecute (
  input  logic                clkH,
  input  logic                reset,
  input  mssdPkg::mssdDecoded decodedOp,
  input  logic                decValid,
  input  logic                queueFull,
  output logic                execHold,
  output mssdPkg::mssdResult  resRec,
  output logic                resPush
);
  import mssdPkg::*;

  logic [dataWidth-1:0]    rdData;
  logic [dataWidth-1:0]    rsData;
  logic [dataWidth-1:0]    src;
  logic [dataWidth-1:0]    dst;
  logic [ipWidth-1:0]      ipReg;
  logic [ipWidth-1:0]      ipNext;
  logic [ipWidth-1:0]      jmpTarget;
  mssdFlags                flagsReg;
  mssdFlags                aluFlags;
  mssdFlags                flagsNext;
  logic [dataWidth-1:0]    aluValue;
  logic                    execValid;
  logic                    execLoad;
  logic                    jumpTaken;
  logic                    isSub;
  logic [dataWidth-1:0]    srcX;
  logic [dataWidth:0]      sumWide;
  logic                    sumOvf;
  logic [shiftWidth-1:0]   shCnt;
  logic                    shLeft;
  logic [shiftWidth:0]     shAmt;
  logic [2*dataWidth:0]    shSrc;
  logic [2*dataWidth:0]    shRes;
  logic                    shCarry;
  logic [dataWidth-1:0]    bitMask;
  logic                    oldBit;

  function automatic logic condHolds(input mssdCond cond, input mssdFlags fl);
    logic smaller;
    smaller = fl.n ^ fl.v;
    case (cond)
      condAlways: condHolds = 1'b1;
      condBe:     condHolds = fl.z | fl.c;
      condC:      condHolds = fl.c;
      condNc:     condHolds = ~fl.c;
      condZ:      condHolds = fl.z;
      condNz:     condHolds = ~fl.z;
      condA:      condHolds = ~fl.z & ~fl.c;
      condG:      condHolds = ~fl.z & ~smaller;
      condGe:     condHolds = fl.z | ~smaller;
      condS:      condHolds = smaller;
      condSe:     condHolds = fl.z | smaller;
      condN:      condHolds = fl.n;
      condV:      condHolds = fl.v;
      condNn:     condHolds = ~fl.n;
      condNv:     condHolds = ~fl.v;
      default:    condHolds = 1'b0;
    endcase
  endfunction

  mssdRegFile i_regFile (
    .clkH   (clkH),
    .reset  (reset),
    .rdIdx  (decodedOp.rd),
    .rsIdx  (decodedOp.rs),
    .wrIdx  (decodedOp.rd),
    .wrEn   (execLoad & decodedOp.regWr),
    .wrData (aluValue),
    .rdData (rdData),
    .rsData (rsData)
  );

  assign dst = rdData;
  assign src = decodedOp.useImm ? decodedOp.immExt : rsData;

  // ********************
  // Sum path
  // ********************
  assign isSub   = (decodedOp.opcode == opSub);
  assign srcX    = isSub ? ~src : src;
  assign sumWide = {1'b0, dst} + {1'b0, srcX} + {{dataWidth{1'b0}}, isSub};
  assign sumOvf  = (dst[dataWidth-1] == srcX[dataWidth-1]) &
                   (sumWide[dataWidth-1] != dst[dataWidth-1]);

  // ********************
  // Barrel shifter
  // ********************
  // Left shifts go right by width minus count; bit 0 catches the carry of right shifts
  assign shCnt  = src[shiftWidth-1:0];
  assign shLeft = (decodedOp.opcode == opShl) | (decodedOp.opcode == opRol);
  assign shAmt  = shLeft ? (shiftWidth + 1)'(dataWidth) - {1'b0, shCnt} : {1'b0, shCnt};

  always_comb begin
    case (decodedOp.opcode)
      opShl:   shSrc = {dst, {dataWidth{1'b0}}, 1'b0};
      opRol:   shSrc = {dst, dst, 1'b0};
      opAsr:   shSrc = {{dataWidth{dst[dataWidth-1]}}, dst, 1'b0};
      default: shSrc = {{dataWidth{1'b0}}, dst, 1'b0};
    endcase
    shRes = shSrc >> shAmt;
    case (decodedOp.opcode)
      opShl:   shCarry = shRes[dataWidth+1];
      opRol:   shCarry = shRes[1];  // Bit wrapped into bit 0
      default: shCarry = shRes[0];
    endcase
    shCarry = shCarry & (|shCnt);
  end

  assign bitMask = {{(dataWidth-1){1'b0}}, 1'b1} << shCnt;
  assign oldBit  = |(dst & bitMask);

  assign jmpTarget = ipReg + decodedOp.immExt[ipWidth-1:0];

  // ********************
  // Result select
  // ********************
  always_comb begin
    aluValue  = '0;
    aluFlags  = flagsReg;
    jumpTaken = 1'b0;
    case (decodedOp.opcode)
      opAdd, opSub: begin
        aluValue   = sumWide[dataWidth-1:0];
        aluFlags.c = sumWide[dataWidth] ^ isSub;  // Borrow on sub
        aluFlags.v = sumOvf;
      end
      opAnd, opXor: begin
        aluValue   = (decodedOp.opcode == opAnd) ? (dst & src) : (dst ^ src);
        aluFlags.c = 1'b0;
        aluFlags.v = 1'b0;
      end
      opShl, opShr, opAsr, opRol: begin
        aluValue   = shRes[dataWidth:1];
        aluFlags.c = shCarry;
        aluFlags.v = 1'b0;
      end
      opBts, opBtr, opBt: begin
        if (decodedOp.opcode == opBts) begin
          aluValue = dst | bitMask;
        end else if (decodedOp.opcode == opBtr) begin
          aluValue = dst & ~bitMask;
        end
        aluFlags = '{v: 1'b0, n: 1'b0, z: 1'b0, c: oldBit};
      end
      opLdi: aluValue = decodedOp.immExt;
      opJmp: begin
        jumpTaken = condHolds(decodedOp.cond, flagsReg);
        aluValue  = jumpTaken ? {{(dataWidth - ipWidth){1'b0}}, jmpTarget} : '0;
      end
      default: ;
    endcase
    if (decodedOp.regWr && !(decodedOp.opcode inside {opBts, opBtr})) begin
      aluFlags.z = (aluValue == '0);
      aluFlags.n = aluValue[dataWidth-1];
    end
  end

  assign flagsNext = decodedOp.flagWr ? aluFlags : flagsReg;
  assign ipNext    = jumpTaken ? jmpTarget : ipReg + 1'b1;

  // ********************
  // Stage register
  // ********************
  assign execHold = execValid & queueFull;
  assign resPush  = execValid & ~queueFull;
  assign execLoad = decValid & ~execHold;

  always_ff @(posedge clkH) begin
    if (reset) begin
      execValid <= 1'b0;
      ipReg     <= '0;
      flagsReg  <= '0;
    end else begin
      if (!execHold) begin
        execValid <= decValid;
      end
      if (execLoad) begin
        ipReg    <= ipNext;
        flagsReg <= flagsNext;
      end
    end
  end

  always_ff @(posedge clkH) begin
    if (execLoad) begin
      resRec <= '{ip: ipReg, opcode: decodedOp.opcode, rd: decodedOp.rd,
                  regWr: decodedOp.regWr, value: aluValue, flags: flagsNext,
                  jumpTaken: jumpTaken};
    end
  end

endmodule

`default_nettype wire

// File: design/mssdResult.sv
`timescale 1ns/100ps
`default_nettype none

module mssdResult (
  input  logic               clkH,
  input  logic               reset,
  input  mssdPkg::mssdResult resRec,
  input  logic               resPush,
  input  logic               resultCredit,
  output logic               queueFull,
  output mssdPkg::mssdResult result,
  output logic               resultValid
);
  import mssdPkg::*;

  mssdResult                queueMem [resultQueueDepth];
  logic [queuePtrWidth-1:0] headPtr;
  logic [queuePtrWidth-1:0] tailPtr;
  logic [queuePtrWidth:0]   queueCount;
  logic [creditWidth-1:0]   creditCount;
  logic                     queueEmpty;
  logic                     haveCredit;
  logic                     bypass;
  logic                     store;
  logic                     popStored;

  assign queueEmpty = (queueCount == '0);
  assign queueFull  = (queueCount == (queuePtrWidth + 1)'(resultQueueDepth));
  assign haveCredit = (creditCount != '0);

  // Empty queue passes the new record straight through
  assign resultValid = haveCredit & (~queueEmpty | resPush);
  assign result      = queueEmpty ? resRec : queueMem[headPtr];
  assign bypass      = queueEmpty & resPush & haveCredit;
  assign store       = resPush & ~bypass;
  assign popStored   = resultValid & ~queueEmpty;

  always_ff @(posedge clkH) begin
    if (store) begin
      queueMem[tailPtr] <= resRec;
    end
  end

  always_ff @(posedge clkH) begin
    if (reset) begin
      headPtr     <= '0;
      tailPtr     <= '0;
      queueCount  <= '0;
      creditCount <= creditWidth'(resultCredits);
    end else begin
      if (store) begin
        tailPtr <= tailPtr + 1'b1;
      end
      if (popStored) begin
        headPtr <= headPtr + 1'b1;
      end
      case ({store, popStored})
        2'b10:   queueCount <= queueCount + 1'b1;
        2'b01:   queueCount <= queueCount - 1'b1;
        default: queueCount <= queueCount;
      endcase
      case ({resultCredit, resultValid})
        2'b10:   creditCount <= creditCount + 1'b1;
        2'b01:   creditCount <= creditCount - 1'b1;
        default: creditCount <= creditCount;  // Returned and spent together
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/mssdCore.sv
`timescale 1ns/100ps
`default_nettype none

module mssdCore (
  input  logic               clkH,
  input  logic               reset,
  input  mssdPkg::mssdInsn   insn,
  input  logic               insnValid,
  input  logic               resultCredit,
  output logic               insnCredit,
  output mssdPkg::mssdResult result,
  output logic               resultValid
);

  // Stage to stage
  mssdPkg::mssdDecoded decodedOp;
  mssdPkg::mssdResult  resRec;
  logic                decValid;
  logic                execHold;
  logic                resPush;
  logic                queueFull;

  mssdDecode i_decode (
    .clkH       (clkH),
    .reset      (reset),
    .insn       (insn),
    .insnValid  (insnValid),
    .execHold   (execHold),
    .insnCredit (insnCredit),
    .decodedOp  (decodedOp),
    .decValid   (decValid)
  );

  mssdExecute i_execute (
    .clkH      (clkH),
    .reset     (reset),
    .decodedOp (decodedOp),
    .decValid  (decValid),
    .queueFull (queueFull),
    .execHold  (execHold),
    .resRec    (resRec),
    .resPush   (resPush)
  );

  mssdResult i_result (
    .clkH         (clkH),
    .reset        (reset),
    .resRec       (resRec),
    .resPush      (resPush),
    .resultCredit (resultCredit),
    .queueFull    (queueFull),
    .result       (result),
    .resultValid  (resultValid)
  );

endmodule

`default_nettype wire

// File: testbench/mssdCore_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module mssdCore_assertions (
  input logic clkH,
  input logic reset,
  input logic insnCredit,
  input logic resultValid,
  input logic resultCredit,
  input logic resPush
);
  import mssdPkg::*;

  logic [creditWidth-1:0] creditModel;  // Credits as seen on the ports
  logic [queuePtrWidth:0] queueModel;   // Records parked in the queue

  always_ff @(posedge clkH) begin
    if (reset) begin
      creditModel <= creditWidth'(resultCredits);
      queueModel  <= '0;
    end else begin
      creditModel <= creditModel + creditWidth'(resultCredit) - creditWidth'(resultValid);
      queueModel  <= queueModel + (queuePtrWidth + 1)'(resPush)
                     - (queuePtrWidth + 1)'(resultValid);
    end
  end

  // ********************
  // Credit rules
  // ********************
  assert property (@(posedge clkH) disable iff (reset) resultValid |-> (creditModel != '0))
    else $error("resultValid raised with no output credits left");

  // ********************
  // Queue rules
  // ********************
  assert property (@(posedge clkH) disable iff (reset)
      resPush |-> (queueModel < (queuePtrWidth + 1)'(resultQueueDepth)))
    else $error("Result queue pushed while full");

  // First cycle out of reset
  assert property (@(posedge clkH) $fell(reset) |-> (!insnCredit && !resultValid))
    else $error("insnCredit or resultValid high right after reset");

endmodule

bind mssdCore mssdCore_assertions i_assertions (
  .clkH         (clkH),
  .reset        (reset),
  .insnCredit   (insnCredit),
  .resultValid  (resultValid),
  .resultCredit (resultCredit),
  .resPush      (resPush)
);

`default_nettype wire

// File: testbench/mssdCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module mssdCoreTb;
  import mssdPkg::*;

  logic      clkH;
  logic      reset;
  mssdInsn   insn;
  logic      insnValid;
  logic      resultCredit;
  logic      insnCredit;
  mssdResult result;
  logic      resultValid;

  mssdInsn   insnQ [$];
  mssdResult expQ [$];
  int        numTests;
  int        sentCount;
  int        recvCount;
  int        sendCredits;
  int        returnedCredits;
  int        heldRecords;  // Consumer slots in use
  logic [31:0] rnd;

  mssdCore i_dut (
    .clkH         (clkH),
    .reset        (reset),
    .insn         (insn),
    .insnValid    (insnValid),
    .resultCredit (resultCredit),
    .insnCredit   (insnCredit),
    .result       (result),
    .resultValid  (resultValid)
  );

  always #5 clkH = ~clkH;

  function automatic logic [31:0] nextRand(input logic [31:0] state);
    nextRand = state * 32'd1664525 + 32'd1013904223;
  endfunction

  // ********************
  // Checks
  // ********************
  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("ERROR at %0t: %s got %h, expected %h", $time, name, got, exp);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkFlags(input mssdFlags got, input mssdFlags exp);
    if (got !== exp) reportMismatch("result.flags", 32'(got), 32'(exp));
  endtask

  task automatic checkResult(input mssdResult got, input mssdResult exp);
    if (got.ip !== exp.ip) reportMismatch("result.ip", 32'(got.ip), 32'(exp.ip));
    if (got.opcode !== exp.opcode) begin
      reportMismatch("result.opcode", 32'(got.opcode), 32'(exp.opcode));
    end
    if (got.rd !== exp.rd) reportMismatch("result.rd", 32'(got.rd), 32'(exp.rd));
    if (got.regWr !== exp.regWr) begin
      reportMismatch("result.regWr", 32'(got.regWr), 32'(exp.regWr));
    end
    if (got.value !== exp.value) reportMismatch("result.value", got.value, exp.value);
    checkFlags(got.flags, exp.flags);
    if (got.jumpTaken !== exp.jumpTaken) begin
      reportMismatch("result.jumpTaken", 32'(got.jumpTaken), 32'(exp.jumpTaken));
    end
  endtask

  task automatic checkCredits(input int got, input int exp);
    if (got != exp) reportMismatch("insnCredit count", 32'(got), 32'(exp));
  endtask

  // ********************
  // Test data
  // ********************
  task automatic loadTestData();
    int          fd;
    int          rc;
    string       line;
    logic [31:0] word;
    logic [15:0] ipv;
    logic        rw;
    logic [2:0]  rdv;
    logic [31:0] val;
    logic [3:0]  fl;
    logic        jt;
    mssdResult   exp;
    fd = $fopen("testbench/mssdCore_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
      $display("Simulation failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      if (rc > 1 && line.getc(0) != "#") begin
        rc = $sscanf(line, "%h %h %h %h %h %h %h", word, ipv, rw, rdv, val, fl, jt);
        if (rc == 7) begin
          exp.ip        = ipv;
          exp.opcode    = mssdOpcode'(word[31:28]);  // Opcode echoes the word
          exp.rd        = rdv;
          exp.regWr     = rw;
          exp.value     = val;
          exp.flags     = fl;
          exp.jumpTaken = jt;
          insnQ.push_back(mssdInsn'(word));
          expQ.push_back(exp);
        end
      end
    end
    $fclose(fd);
    numTests = insnQ.size();
    if (numTests == 0) begin
      $display("The test data file holds no instructions");
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // ********************
  // Stimulus
  // ********************
  initial begin
    clkH = 1'b0;
    reset = 1'b1;
    insn = '0;
    insnValid = 1'b0;
    resultCredit = 1'b0;
    numTests = 0;
    sentCount = 0;
    recvCount = 0;
    sendCredits = insnBufDepth;
    returnedCredits = 0;
    heldRecords = 0;
    rnd = 32'hf340_f98d;
    loadTestData();
    repeat (3) @(posedge clkH);
    @(negedge clkH);
    reset = 1'b0;
    while (recvCount < numTests) begin
      @(negedge clkH);
      if (insnCredit) begin
        sendCredits++;
        returnedCredits++;
      end
      if (resultValid) begin
        if (heldRecords >= resultCredits) begin
          $display("Result record arrived with no free consumer slot");
          $display("Simulation failed");
          $fatal(1);
        end
        checkResult(result, expQ[recvCount]);
        recvCount++;
        heldRecords++;
      end
      if (sentCount < numTests && sendCredits > 0) begin
        insn = insnQ[sentCount];
        insnValid = 1'b1;
        sendCredits--;
        sentCount++;
      end else begin
        insn = '0;
        insnValid = 1'b0;
      end
      rnd = nextRand(rnd);
      if (heldRecords > 0 && rnd[20]) begin  // Random consumer drain
        resultCredit = 1'b1;
        heldRecords--;
      end else begin
        resultCredit = 1'b0;
      end
    end
    @(negedge clkH);
    insnValid = 1'b0;
    resultCredit = 1'b0;
    checkCredits(returnedCredits, sentCount);
    $display("Simulation completed successfully");
    $finish;
  end

  // Watchdog scaled to the test length
  initial begin
    wait (numTests > 0);
    repeat (numTests * 40 + 200) @(posedge clkH);
    $display("Timeout with %0d of %0d result records received", recvCount, numTests);
    $display("Simulation failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: vlog.f
design/mssdPkg.sv
design/mssdRegFile.sv
design/mssdDecode.sv
design/mssdExecute.sv
design/mssdResult.sv
design/mssdCore.sv
testbench/mssdCore_assertions.sv
testbench/mssdCoreTb.sv

// File: run.sh
#!/bin/bash
# Build and run the mssdCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module mssdCoreTb \
  -o simv > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"

if grep -q "Simulation failed" "$SIM_LOG"; then
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "Simulator exited with status $simStatus"
  exit 1
fi
exit 0

// File: testbench/mssdCore_testdata.txt
# insn     ip   regWr rd value    flags(VNZC) jumpTaken
# all fields hex, one instruction per line in program order
B0230001 0000 1 1 00000001 0 0
4023001F 0001 1 1 80000000 4 0
0023FFFF 0002 1 1 7FFFFFFF 9 0
00230001 0003 1 1 80000000 C 0
B0420005 0004 1 2 00000005 C 0
10430006 0005 1 2 FFFFFFFF 5 0
10230001 0006 1 1 7FFFFFFF 8 0
10490000 0007 1 2 00000000 2 0
C4000010 0008 0 0 00000018 2 1
C5000010 0018 0 0 00000000 2 0
C1000010 0019 0 0 00000029 2 1
C7000010 0029 0 0 00000000 2 0
C9000010 002A 0 0 0000003A 2 1
C6000010 003A 0 0 00000000 2 0
2023FFFF 003B 1 1 7FFFFFFF 0 0
C8000010 003C 0 0 0000004C 0 1
C0000010 004C 0 0 0000005C 0 1
C2000010 005C 0 0 00000000 0 0
C3000010 005D 0 0 0000006D 0 1
3023FFFF 006D 1 1 80000000 4 0
CA000010 006E 0 0 0000007E 4 1
CB000010 007E 0 0 0000008E 4 1
CC000010 008E 0 0 0000009E 4 1
CE000010 009E 0 0 00000000 4 0
CD000010 009F 0 0 00000000 4 0
CF000010 00A0 0 0 000000B0 4 1
60230001 00B0 1 1 C0000000 4 0
70230001 00B1 1 1 80000001 5 0
50230000 00B2 1 1 80000001 4 0
50230001 00B3 1 1 40000000 1 0
40230001 00B4 1 1 80000000 4 0
40230001 00B5 1 1 00000000 3 0
B062FFFD 00B6 1 3 FFFFFFFD 3 0
7063001F 00B7 1 3 FFFFFFFE 4 0
70630000 00B8 1 3 FFFFFFFE 4 0
6063001F 00B9 1 3 FFFFFFFF 5 0
80430005 00BA 1 2 00000020 0 0
A0430005 00BB 0 2 00000000 1 0
90430005 00BC 1 2 00000000 1 0
A0430005 00BD 0 2 00000000 0 0
8043001F 00BE 1 2 80000000 0 0
A042001F 00BF 0 2 00000000 0 0
00430000 00C0 1 2 80000000 4 0
30490000 00C1 1 2 00000000 2 0
002C0000 00C2 1 1 FFFFFFFF 2 0
C4000010 00C3 0 0 000000D3 2 1
